/* dma_pkg.sv */
`default_nettype none

package dma_pkg;

	// bus widths on the cpu side.
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// the dma page register sits in the i/o page.
	localparam logic [addr_w-1:0] dma_reg_addr = 16'hFF46;

	// object attribute memory, mapped at the bottom of page 0xfe.
	localparam logic [addr_w-1:0] oam_base = 16'hFE00;
	localparam int oam_addr_w = 8;
	localparam logic [oam_addr_w-1:0] oam_len = 8'd160;

	// clocks from the register write to the first copy cycle.
	localparam int start_delay = 2;
	localparam int delay_w = $clog2(start_delay + 1);

	// source address bits 15..13 equal to this value select video ram.
	// any other value goes to the external bus.
	localparam logic [2:0] vram_region = 3'b100;

endpackage

`default_nettype wire

/* dma_page_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_page_reg
	import dma_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [addr_w-1:0] cpu_addr,
	input  logic              cpu_wr,
	input  logic [data_w-1:0] cpu_wdata,
	output logic [data_w-1:0] page,
	output logic [data_w-1:0] page_rdata,
	output logic              page_hit,
	output logic              start_req
);

	logic page_wr;

	assign page_hit = (cpu_addr == dma_reg_addr);
	assign page_wr  = cpu_wr && page_hit;

	// the register is fully readable, so readback is just the stored page.
	assign page_rdata = page;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			page <= '0;
		end else if (page_wr) begin
			page <= cpu_wdata;
		end
	end

	// every write starts a transfer, even when the page value is unchanged.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			start_req <= 1'b0;
		end else begin
			start_req <= page_wr;
		end
	end

endmodule

`default_nettype wire

/* dma_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_sequencer
	import dma_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start_req,
	output logic                  dma_run,
	output logic                  copy_en,
	output logic [oam_addr_w-1:0] offset
);

	logic [delay_w-1:0] pend_cnt;
	logic               pending;
	logic               last_byte;

	// the page register already spends one clock of the start delay.
	// the rest is counted here.
	assign pending   = (pend_cnt != '0);
	assign last_byte = copy_en && (offset == oam_len - 8'd1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_cnt <= '0;
		end else if (start_req) begin
			pend_cnt <= delay_w'(start_delay - 1);
		end else if (pending) begin
			pend_cnt <= pend_cnt - 1'b1;
		end
	end

	// a request in the middle of a copy stops it and rearms the delay.
	// dma_run is left alone then, so oam stays busy across the restart.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dma_run <= 1'b0;
			copy_en <= 1'b0;
		end else if (start_req) begin
			copy_en <= 1'b0;
		end else if (pending && pend_cnt == delay_w'(1)) begin
			dma_run <= 1'b1;
			copy_en <= 1'b1;
		end else if (last_byte) begin
			dma_run <= 1'b0;
			copy_en <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			offset <= '0;
		end else if (start_req || last_byte) begin
			offset <= '0;
		end else if (copy_en) begin
			offset <= offset + 1'b1;
		end
	end

	// the oam index must stay inside the 160 byte array.
	a_offset_in_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		copy_en |-> (offset < oam_len)
	);

	// oam is reported busy for every cycle that writes it.
	a_copy_in_run: assert property (
		@(posedge clk) disable iff (!arst_n)
		copy_en |-> dma_run
	);

	// a lone request is followed by copying once the delay has run out.
	a_start_latency: assert property (
		@(posedge clk) disable iff (!arst_n)
		start_req ##1 !start_req |=> copy_en
	);

endmodule

`default_nettype wire

/* dma_source_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_source_mux
	import dma_pkg::*;
(
	input  logic [data_w-1:0]     page,
	input  logic [oam_addr_w-1:0] offset,
	input  logic                  copy_en,
	input  logic [data_w-1:0]     vram_rdata,
	input  logic [data_w-1:0]     ext_rdata,
	output logic [addr_w-1:0]     src_addr,
	output logic                  src_vram_rd,
	output logic                  src_ext_rd,
	output logic [data_w-1:0]     copy_data
);

	logic vram_sel;

	// the page is the high byte of the source address.
	assign src_addr = {page, offset};

	// page bits 7..5 are address bits 15..13, so pages 0x80 to 0x9f hit video ram.
	assign vram_sel = (page[7:5] == vram_region);

	assign src_vram_rd = copy_en && vram_sel;
	assign src_ext_rd  = copy_en && !vram_sel;

	// both memories answer in the same cycle, so the byte is steered straight through.
	assign copy_data = vram_sel ? vram_rdata : ext_rdata;

endmodule

`default_nettype wire

/* oam_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module oam_ram
	import dma_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  dma_run,
	input  logic                  copy_en,
	input  logic [oam_addr_w-1:0] offset,
	input  logic [data_w-1:0]     copy_data,
	input  logic [addr_w-1:0]     cpu_addr,
	input  logic                  cpu_wr,
	input  logic [data_w-1:0]     cpu_wdata,
	output logic [data_w-1:0]     oam_rdata,
	output logic                  oam_hit
);

	logic [data_w-1:0]     mem [oam_len];
	logic [addr_w-1:0]     cpu_off;
	logic [oam_addr_w-1:0] cpu_idx;

	// an address below the base wraps to a large offset and misses.
	assign cpu_off = cpu_addr - oam_base;
	assign cpu_idx = cpu_off[oam_addr_w-1:0];
	assign oam_hit = (cpu_off < addr_w'(oam_len));

	// the dma port wins, and the cpu port is locked out for the whole run.
	always_ff @(posedge clk) begin
		if (copy_en) begin
			mem[offset] <= copy_data;
		end else if (cpu_wr && oam_hit && !dma_run) begin
			mem[cpu_idx] <= cpu_wdata;
		end
	end

	// the cpu sees an open bus while oam is busy.
	assign oam_rdata = (oam_hit && !dma_run) ? mem[cpu_idx] : 8'hFF;

	// a blocked cpu write must not disturb the byte it aimed at.
	a_cpu_write_blocked: assert property (
		@(posedge clk) disable iff (!arst_n)
		(cpu_wr && oam_hit && dma_run && !(copy_en && offset == cpu_idx))
		|=> (mem[$past(cpu_idx)] == $past(mem[cpu_idx]))
	);

endmodule

`default_nettype wire

/* dma_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_top
	import dma_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [addr_w-1:0] cpu_addr,
	input  logic              cpu_wr,
	input  logic              cpu_rd,
	input  logic [data_w-1:0] cpu_wdata,
	output logic [data_w-1:0] cpu_rdata,
	output logic [addr_w-1:0] src_addr,
	output logic              src_vram_rd,
	output logic              src_ext_rd,
	input  logic [data_w-1:0] vram_rdata,
	input  logic [data_w-1:0] ext_rdata,
	output logic              dma_run
);

	logic [data_w-1:0]     page;
	logic [data_w-1:0]     page_rdata;
	logic                  page_hit;
	logic                  start_req;
	logic                  copy_en;
	logic [oam_addr_w-1:0] offset;
	logic [data_w-1:0]     copy_data;
	logic [data_w-1:0]     oam_rdata;
	logic                  oam_hit;

	dma_page_reg i_dma_page_reg (
		.clk        (clk),
		.arst_n     (arst_n),
		.cpu_addr   (cpu_addr),
		.cpu_wr     (cpu_wr),
		.cpu_wdata  (cpu_wdata),
		.page       (page),
		.page_rdata (page_rdata),
		.page_hit   (page_hit),
		.start_req  (start_req)
	);

	dma_sequencer i_dma_sequencer (
		.clk       (clk),
		.arst_n    (arst_n),
		.start_req (start_req),
		.dma_run   (dma_run),
		.copy_en   (copy_en),
		.offset    (offset)
	);

	dma_source_mux i_dma_source_mux (
		.page        (page),
		.offset      (offset),
		.copy_en     (copy_en),
		.vram_rdata  (vram_rdata),
		.ext_rdata   (ext_rdata),
		.src_addr    (src_addr),
		.src_vram_rd (src_vram_rd),
		.src_ext_rd  (src_ext_rd),
		.copy_data   (copy_data)
	);

	oam_ram i_oam_ram (
		.clk       (clk),
		.arst_n    (arst_n),
		.dma_run   (dma_run),
		.copy_en   (copy_en),
		.offset    (offset),
		.copy_data (copy_data),
		.cpu_addr  (cpu_addr),
		.cpu_wr    (cpu_wr),
		.cpu_wdata (cpu_wdata),
		.oam_rdata (oam_rdata),
		.oam_hit   (oam_hit)
	);

	// unmapped addresses and idle cycles read as an open bus
	always_comb begin
		cpu_rdata = 8'hFF;
		if (cpu_rd) begin
			if (page_hit) begin
				cpu_rdata = page_rdata;
			end else if (oam_hit) begin
				cpu_rdata = oam_rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_dma.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dma
	import dma_pkg::*;
();

	localparam int seed = 37682;
	localparam int last_edge = start_delay + int'(oam_len);
	localparam int xfer_cycles = 2 * int'(oam_len) + 64;
	localparam int watchdog_ns = 40 * xfer_cycles * 10;

	logic              clk = 1'b0;
	logic              arst_n;
	logic [addr_w-1:0] cpu_addr;
	logic              cpu_wr;
	logic              cpu_rd;
	logic [data_w-1:0] cpu_wdata;
	logic [data_w-1:0] cpu_rdata;
	logic [addr_w-1:0] src_addr;
	logic              src_vram_rd;
	logic              src_ext_rd;
	logic [data_w-1:0] vram_rdata;
	logic [data_w-1:0] ext_rdata;
	logic              dma_run;

	logic [7:0]  vram_mem [8192];
	logic [7:0]  ext_mem [65536];
	logic [7:0]  oam_model [oam_len];
	logic [7:0]  page_exp;
	logic        run_exp;
	logic        active;
	int          since;
	int          value_errors;
	int          other_errors;
	logic [31:0] rng_state;

	dma_top i_dma_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.cpu_addr    (cpu_addr),
		.cpu_wr      (cpu_wr),
		.cpu_rd      (cpu_rd),
		.cpu_wdata   (cpu_wdata),
		.cpu_rdata   (cpu_rdata),
		.src_addr    (src_addr),
		.src_vram_rd (src_vram_rd),
		.src_ext_rd  (src_ext_rd),
		.vram_rdata  (vram_rdata),
		.ext_rdata   (ext_rdata),
		.dma_run     (dma_run)
	);

	always #5 clk = ~clk;

	// both source memories answer in the same cycle, and only on their own strobe.
	assign vram_rdata = src_vram_rd ? vram_mem[src_addr[12:0]] : 8'h00;
	assign ext_rdata  = src_ext_rd ? ext_mem[src_addr] : 8'h00;

	function logic [31:0] rand32();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [7:0] vram_fill(input logic [12:0] a);
		return a[7:0] ^ {a[12:8], 3'b101} ^ 8'h3C;
	endfunction

	function automatic logic [7:0] ext_fill(input logic [15:0] a);
		return (a[7:0] * 8'd13) ^ a[15:8] ^ 8'hA5;
	endfunction

	function automatic logic [7:0] src_byte(input logic [7:0] page, input int off);
		if (page[7:5] == vram_region) begin
			return vram_mem[{page[4:0], off[7:0]}];
		end
		return ext_mem[{page, off[7:0]}];
	endfunction

	function automatic logic [7:0] pick_page(input logic want_vram);
		logic [31:0] r;
		logic [7:0]  p;
		r = rand32();
		p = r[23:16];
		if (want_vram) begin
			p = {vram_region, p[4:0]};
		end else if (p[7:5] == vram_region) begin
			p[7] = 1'b0;
		end
		return p;
	endfunction

	task automatic report_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		value_errors++;
		$display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	// reference model. checks use the state before the edge, then the state advances.
	always @(posedge clk) begin
		logic [7:0] exp_rdata;
		logic       exp_vram;
		logic       copy_now;
		logic       in_oam;
		int         idx;
		if (arst_n) begin
			copy_now = active && since >= start_delay && since < last_edge;
			idx = int'(cpu_addr) - int'(oam_base);
			in_oam = idx >= 0 && idx < int'(oam_len);
			if (dma_run !== run_exp) report_value("dma_run", run_exp, dma_run);
			if (copy_now) begin
				exp_vram = (page_exp[7:5] == vram_region);
				if (src_vram_rd !== exp_vram) report_value("src_vram_rd", exp_vram, src_vram_rd);
				if (src_ext_rd !== !exp_vram) report_value("src_ext_rd", !exp_vram, src_ext_rd);
				if (src_addr !== {page_exp, 8'(since - start_delay)}) begin
					report_value("src_addr", {page_exp, 8'(since - start_delay)}, src_addr);
				end
			end else if (!(active && since == 0 && run_exp)) begin
				// right after a restart the old copy cycle may still be in flight.
				if (src_vram_rd !== 1'b0) report_value("src_vram_rd", 1'b0, src_vram_rd);
				if (src_ext_rd !== 1'b0) report_value("src_ext_rd", 1'b0, src_ext_rd);
			end
			if (cpu_rd) begin
				exp_rdata = 8'hFF;
				if (cpu_addr == dma_reg_addr) begin
					exp_rdata = page_exp;
				end else if (in_oam && !run_exp) begin
					exp_rdata = oam_model[idx];
				end
				if (cpu_rdata !== exp_rdata) report_value("cpu_rdata", exp_rdata, cpu_rdata);
			end
			if (cpu_wr && in_oam && !run_exp) oam_model[idx] = cpu_wdata;
			if (copy_now) begin
				oam_model[since - start_delay] = src_byte(page_exp, since - start_delay);
			end
			if (active) begin
				since++;
				if (since == start_delay) begin
					run_exp = 1'b1;
				end else if (since == last_edge) begin
					run_exp = 1'b0;
					active = 1'b0;
				end
			end
			if (cpu_wr && cpu_addr == dma_reg_addr) begin
				since = 0;
				active = 1'b1;
				page_exp = cpu_wdata;
			end
		end
	end

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_wr = 1'b1;
		@(negedge clk);
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		@(negedge clk);
		cpu_addr = addr;
		cpu_rd = 1'b1;
		@(negedge clk);
		cpu_rd = 1'b0;
	endtask

	task automatic read_all_oam();
		for (int i = 0; i < int'(oam_len); i++) begin
			cpu_read(oam_base + 16'(i));
		end
	endtask

	// the run first has to rise after the start delay, then fall after the last byte.
	task automatic wait_done();
		int n;
		n = 0;
		while (dma_run !== 1'b1 && n < start_delay + 4) begin
			@(negedge clk);
			n++;
		end
		if (dma_run !== 1'b1) begin
			other_errors++;
			$display("dma_run never rose after the page write, time %0t", $time);
		end
		n = 0;
		while (dma_run !== 1'b0 && n < last_edge + 8) begin
			@(negedge clk);
			n++;
		end
		if (dma_run !== 1'b0) begin
			other_errors++;
			$display("transfer did not finish, dma_run still high at %0t", $time);
		end
	endtask

	task automatic oam_traffic(input int n);
		logic [31:0] r;
		logic [15:0] addr;
		repeat (n) begin
			r = rand32();
			addr = oam_base + 16'(r[23:16] % oam_len);
			case (r[5:4])
				2'd0: cpu_write(addr, r[15:8]);
				2'd3: cpu_read(dma_reg_addr);
				default: cpu_read(addr);
			endcase
			idle(int'(r[1:0]));
		end
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired, the run hung at %0t", $time);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		rng_state = seed;
		value_errors = 0;
		other_errors = 0;
		page_exp = 8'h00;
		run_exp = 1'b0;
		active = 1'b0;
		since = 0;
		for (int a = 0; a < 8192; a++) vram_mem[a] = vram_fill(13'(a));
		for (int a = 0; a < 65536; a++) ext_mem[a] = ext_fill(16'(a));
		arst_n = 1'b0;
		cpu_addr = '0;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		cpu_wdata = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		if (dma_run !== 1'b0) report_value("dma_run", 1'b0, dma_run);
		if (src_vram_rd !== 1'b0) report_value("src_vram_rd", 1'b0, src_vram_rd);
		if (src_ext_rd !== 1'b0) report_value("src_ext_rd", 1'b0, src_ext_rd);
		cpu_read(dma_reg_addr);
		for (int v = 0; v < 2; v++) begin
			repeat (3) begin
				cpu_write(dma_reg_addr, pick_page(v[0]));
				cpu_read(dma_reg_addr);
				wait_done();
				read_all_oam();
			end
		end
		// cpu traffic while oam is busy, then after it is free again.
		r = rand32();
		cpu_write(dma_reg_addr, pick_page(r[20]));
		oam_traffic(40);
		wait_done();
		oam_traffic(200);
		repeat (2) begin
			cpu_write(dma_reg_addr, pick_page(1'b0));
			r = rand32();
			idle(10 + int'(r[23:16]) % 120);
			cpu_write(dma_reg_addr, pick_page(1'b1));
			wait_done();
			read_all_oam();
		end
		idle(4);
		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
dma_pkg.sv
dma_page_reg.sv
dma_sequencer.sv
dma_source_mux.sv
oam_ram.sv
dma_top.sv
tb_dma.sv

/* Bender.yml */
package:
  name: dma

sources:
  - dma_pkg.sv
  - dma_page_reg.sv
  - dma_sequencer.sv
  - dma_source_mux.sv
  - oam_ram.sv
  - dma_top.sv
  - target: simulation
    files:
      - tb_dma.sv
